// ==== cpuFrontEnd.f ====
+incdir+.
cpuTypesPkg.sv
decodeTablePkg.sv
fetchStage.sv
interruptControl.sv
cycleTimer.sv
decodeSlice.sv
controlMerge.sv
cpuFrontEnd.sv
cpuFrontEnd_tb.sv

// ==== frontEndChecks.svh ====
// Expected-value functions and concurrent checks for the front end testbench

// Table decode of one opcode in one T-state
function automatic ctrlWordT tableDecode(
    input logic [DATA_W-1:0] op,
    input tStateT            ts
);
    logic [CTRL_W-1:0] bits;
    bits = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (((PLA_ROWS[r].tSel & ts) != '0)
                && ((op & PLA_ROWS[r].mask) == PLA_ROWS[r].value)) begin
            bits |= PLA_ROWS[r].ctrlBit;   // Every hit row adds its bit
        end
    end
    return ctrlWordT'(bits);
endfunction

// T5 always ends, so no wrap is needed
function automatic tStateT stepState(input tStateT ts);
    return {ts[NUM_T_STATES-2:0], 1'b0};
endfunction

function automatic intSourceT pickSource(input logic res, input logic nmi, input logic irq);
    if (res) begin
        return SRC_RES;
    end else if (nmi) begin
        return SRC_NMI;
    end else if (irq) begin
        return SRC_IRQ;
    end
    return SRC_NONE;
endfunction

resetValues: assert property (@(posedge NMI_L) $rose(rstN) |->
    {tState, sync, ctrl, activeSource} == {TS_T0, 1'b1, 12'h000, SRC_RES})
    else reportMismatch("resetValues", {TS_T0, 1'b1, 12'h000, SRC_RES},
                        $sampled({tState, sync, ctrl, activeSource}));

ctrlTrack: assert property (@(posedge NMI_L) disable iff (!rstN) ctrl == mCtrl)
    else reportMismatch("ctrlTrack", $sampled(mCtrl), $sampled(ctrl));

writeTrack: assert property (@(posedge NMI_L) disable iff (!rstN) writeCycle == mWrite)
    else reportMismatch("writeTrack", $sampled(mWrite), $sampled(writeCycle));

stateTrack: assert property (@(posedge NMI_L) disable iff (!rstN)
    {tState, sync} == {mTs, mTs[0]})   // sync is T0
    else reportMismatch("stateTrack", $sampled({mTs, mTs[0]}), $sampled({tState, sync}));

irTrack: assert property (@(posedge NMI_L) disable iff (!rstN) irOpcode.raw == mIr)
    else reportMismatch("irTrack", $sampled(mIr), $sampled(irOpcode.raw));

sourceTrack: assert property (@(posedge NMI_L) disable iff (!rstN) activeSource == mSrc)
    else reportMismatch("sourceTrack", $sampled(mSrc), $sampled(activeSource));

loadStartsT0: assert property (@(posedge NMI_L) disable iff (!rstN) mLoad |=> tState == TS_T0)
    else reportMismatch("loadStartsT0", TS_T0, $sampled(tState));

// Stall without a write freezes the front end
stallHold: assert property (@(posedge NMI_L) disable iff (!rstN)
    !rdy && !writeCycle |=> {tState, irOpcode.raw, activeSource} == {prevTs, prevOp, prevSrc})
    else reportMismatch("stallHold", $sampled({prevTs, prevOp, prevSrc}),
                        $sampled({tState, irOpcode.raw, activeSource}));

// ==== cpuFrontEnd_tb.sv ====
// Front end testbench with clock, reset, LFSR stimulus, reference model, watchdog and DUT
`timescale 1ns/1ps

module cpuFrontEnd_tb;
    import cpuTypesPkg::*;
    import decodeTablePkg::*;

    localparam int          CLK_PERIOD       = 4;
    localparam int          RESET_CYCLES     = 5;
    localparam int          NUM_INSTR        = 300;   // Random instructions
    localparam int          DIRECTED_INSTR   = 20;    // Priority and reset tail
    localparam int          CYCLES_PER_INSTR = 40;
    localparam int          TIMEOUT_NS       =
        CYCLES_PER_INSTR * (NUM_INSTR + DIRECTED_INSTR) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED        = 32'h88ae097d;
    localparam logic [31:0] LFSR_TAPS        = 32'h80200003;
    // Opcodes that the row table decodes
    localparam logic [DATA_W-1:0] OPCODE_LIST [32] = '{
        8'h09, 8'h05, 8'h0D, 8'h29, 8'h25, 8'h2D, 8'h49, 8'h45,
        8'h4D, 8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED, 8'hA9,
        8'hA5, 8'hAD, 8'h85, 8'h8D, 8'h81, 8'h48, 8'h08, 8'h68,
        8'h28, 8'h4C, 8'h6C, 8'h20, 8'h40, 8'h60, 8'h00, 8'h91
    };

    logic              NMI_L;
    logic              rstN;
    logic [DATA_W-1:0] dataIn;
    logic              rdy;
    intReqT            intReq;
    logic              sync;
    tStateT            tState;
    opcodeU            irOpcode;
    ctrlWordT          ctrl;
    logic              writeCycle;
    intSourceT         activeSource;

    logic [DATA_W-1:0] mPre;           // Model predecode byte
    logic [DATA_W-1:0] mIr;
    tStateT            mTs;
    ctrlWordT          mCtrl;
    intSourceT         mSrc;
    logic              nmiNow;         // NMI pin, one and two edges back
    logic              nmiOld;
    logic              pendNmi;
    logic              pendIrq;
    logic              pendRes;
    tStateT            prevTs;         // DUT outputs one edge back
    logic [DATA_W-1:0] prevOp;
    intSourceT         prevSrc;
    int                loadCount;
    logic [31:0]       lfsrState = LFSR_SEED;
    ctrlWordT          mDecode;
    logic              mWrite;
    logic              mReady;
    logic              mLoad;
    logic              mForce;
    intSourceT         mPick;

    `include "frontEndChecks.svh"

    assign mDecode = tableDecode(mIr, mTs);
    assign mWrite  = mDecode.storeA | mDecode.pushStack;
    assign mReady  = rdy | mWrite;                              // Writes ignore rdy
    assign mLoad   = (mDecode.endInstr | mTs[NUM_T_STATES-1]) & mReady;
    assign mForce  = pendNmi | pendIrq | pendRes;
    assign mPick   = pickSource(pendRes, pendNmi, pendIrq);

    cpuFrontEnd dut_i (
        .NMI_L        (NMI_L),
        .rstN         (rstN),
        .dataIn       (dataIn),
        .rdy          (rdy),
        .intReq       (intReq),
        .sync         (sync),
        .tState       (tState),
        .irOpcode     (irOpcode),
        .ctrl         (ctrl),
        .writeCycle   (writeCycle),
        .activeSource (activeSource)
    );

    always #(CLK_PERIOD / 2) NMI_L = ~NMI_L;

    // Reference model of the front end
    always @(posedge NMI_L) begin
        prevTs  <= tState;
        prevOp  <= irOpcode.raw;
        prevSrc <= activeSource;
        if (!rstN) begin
            {mPre, mIr, mCtrl, pendNmi, pendIrq, pendRes} <= '0;
            {nmiNow, nmiOld} <= 2'b11;
            mTs       <= TS_T0;
            mSrc      <= SRC_RES;
            loadCount <= 0;
        end else begin
            mCtrl  <= mDecode;
            nmiNow <= intReq.nmiN;
            nmiOld <= nmiNow;
            if (mReady) begin
                mPre <= dataIn;
                mTs  <= mLoad ? TS_T0 : stepState(mTs);
            end
            if (mLoad) begin
                mIr       <= mForce ? INT_OPCODE : mPre;   // Interrupt replaces the fetch
                loadCount <= loadCount + 1;
            end
            if (nmiOld && !nmiNow) begin
                pendNmi <= 1'b1;                          // New edge outlives a take
            end else if (mLoad && mPick == SRC_NMI) begin
                pendNmi <= 1'b0;
            end
            if (mLoad && mPick == SRC_IRQ) begin
                pendIrq <= 1'b0;
            end else if (!intReq.irqN) begin
                pendIrq <= 1'b1;
            end
            if (mLoad && mPick == SRC_RES) begin
                pendRes <= 1'b0;
            end else if (!intReq.resN) begin
                pendRes <= 1'b1;
            end
            if (mLoad && mForce) begin
                mSrc <= mPick;
            end
        end
    end

    // Galois step, one call per random bit
    function automatic logic lfsrStep();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState ^= LFSR_TAPS;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrStep()};
        end
        return r;
    endfunction

    task automatic stopWithFailure();
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        stopWithFailure();
    endtask

    task automatic driveRandomCycle();
        @(posedge NMI_L);
        dataIn      <= OPCODE_LIST[randBits(5)];
        rdy         <= (randBits(2) != '0);      // Low one cycle in four
        intReq.nmiN <= (randBits(4) != '0);
        intReq.irqN <= (randBits(4) != '0);
        intReq.resN <= (randBits(6) != '0);      // Rare reset pulse
    endtask

    // Returns after the edge that loads the IR
    task automatic waitLoad();
        @(posedge NMI_L);
        while (!mLoad) begin
            @(posedge NMI_L);
        end
    endtask

    task automatic quietPins();
        @(posedge NMI_L);
        rdy    <= 1'b1;
        intReq <= '1;
        repeat (3) @(posedge NMI_L);             // NMI edge pipe settles
        while (mForce) begin
            waitLoad();
        end
    endtask

    initial begin
        NMI_L  = 1'b0;
        rstN   = 1'b0;
        dataIn = '0;
        rdy    = 1'b1;
        intReq = '1;
        repeat (RESET_CYCLES) @(posedge NMI_L);
        rstN <= 1'b1;
        while (loadCount < NUM_INSTR) begin
            driveRandomCycle();
        end
        quietPins();
        intReq.nmiN <= 1'b0;                     // NMI and IRQ together
        intReq.irqN <= 1'b0;
        repeat (3) waitLoad();
        quietPins();
        intReq.resN <= 1'b0;
        repeat (3) @(posedge NMI_L);
        intReq.resN <= 1'b1;
        repeat (2) waitLoad();
        repeat (2) @(posedge NMI_L);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        stopWithFailure();
    end

endmodule

// ==== cpuFrontEnd.sv ====
// Processor front end top with fetch, interrupt, timer, merge and per-state decode slices
`timescale 1ns/1ps

module cpuFrontEnd (
    input  logic                           NMI_L,        // Core clock
    input  logic                           rstN,         // Sync reset
    input  logic [cpuTypesPkg::DATA_W-1:0] dataIn,       // External data bus
    input  logic                           rdy,          // External ready
    input  cpuTypesPkg::intReqT            intReq,       // NMI, IRQ, RES requests
    output logic                           sync,         // Opcode fetch cycle
    output cpuTypesPkg::tStateT            tState,       // One-hot T-state
    output cpuTypesPkg::opcodeU            irOpcode,     // Instruction register
    output cpuTypesPkg::ctrlWordT          ctrl,         // Registered control word
    output logic                           writeCycle,   // Bus write this cycle
    output cpuTypesPkg::intSourceT         activeSource  // Serviced interrupt
);
    import cpuTypesPkg::*;
    import decodeTablePkg::*;

    logic                                    ready;      // rdy or write
    logic                                    irLoad;     // IR load strobe
    logic                                    forceInt;   // Interrupt pending
    logic                                    lastCycle;  // Instruction ends
    logic [NUM_T_STATES-1:0][NUM_ROWS-1:0]   sliceHits;  // Per-slice row hits

    fetchStage fetch_i (
        .NMI_L    (NMI_L),
        .rstN     (rstN),
        .dataIn   (dataIn),
        .ready    (ready),
        .irLoad   (irLoad),
        .forceInt (forceInt),
        .irOpcode (irOpcode)
    );

    interruptControl intCtl_i (
        .NMI_L        (NMI_L),
        .rstN         (rstN),
        .intReq       (intReq),
        .irLoad       (irLoad),
        .forceInt     (forceInt),
        .activeSource (activeSource)
    );

    cycleTimer timer_i (
        .NMI_L     (NMI_L),
        .rstN      (rstN),
        .rdy       (rdy),
        .writeNow  (writeCycle),
        .lastCycle (lastCycle),
        .tState    (tState),
        .ready     (ready),
        .irLoad    (irLoad),
        .sync      (sync)
    );

    // One PLA slice per T-state
    for (genvar s = 0; s < NUM_T_STATES; s++) begin : gSlice
        decodeSlice #(
            .SLICE_IDX (s)
        ) slice_i (
            .irOpcode    (irOpcode),
            .stateActive (tState[s]),
            .rowHits     (sliceHits[s])
        );
    end

    controlMerge merge_i (
        .NMI_L     (NMI_L),
        .rstN      (rstN),
        .sliceHits (sliceHits),
        .tState    (tState),
        .ctrl      (ctrl),
        .lastCycle (lastCycle),
        .writeNow  (writeCycle)
    );

endmodule

// ==== controlMerge.sv ====
// Row hit merge, control word register, end-of-instruction and write-cycle decode
`timescale 1ns/1ps

module controlMerge (
    input  logic                  NMI_L,      // Core clock
    input  logic                  rstN,       // Sync reset
    input  logic [cpuTypesPkg::NUM_T_STATES-1:0][decodeTablePkg::NUM_ROWS-1:0] sliceHits,
    input  cpuTypesPkg::tStateT   tState,     // Current T-state
    output cpuTypesPkg::ctrlWordT ctrl,       // Decode of last cycle
    output logic                  lastCycle,  // Instruction ends now
    output logic                  writeNow    // Bus write now
);
    import cpuTypesPkg::*;
    import decodeTablePkg::*;

    logic [NUM_ROWS-1:0] rowHit;      // Hits over all slices
    logic [CTRL_W-1:0]   decodeBits;  // OR of hit rows' control bits
    ctrlWordT            decoded;

    always_comb begin
        rowHit = '0;
        for (int s = 0; s < NUM_T_STATES; s++) begin
            rowHit |= sliceHits[s];   // Only the active slice can hit
        end
    end

    always_comb begin
        decodeBits = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rowHit[r]) begin
                decodeBits |= PLA_ROWS[r].ctrlBit;
            end
        end
    end

    assign decoded   = ctrlWordT'(decodeBits);
    assign lastCycle = decoded.endInstr | (tState == TS_T5);  // T5 caps every instruction
    assign writeNow  = decoded.storeA | decoded.pushStack;

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            ctrl <= '0;
        end else begin
            ctrl <= decoded;   // One cycle of latency
        end
    end

endmodule

// ==== decodeSlice.sv ====
// PLA match of the instruction register for the rows of one T-state
`timescale 1ns/1ps

module decodeSlice #(
    parameter int SLICE_IDX = 0                            // T-state served
) (
    input  cpuTypesPkg::opcodeU                 irOpcode,     // Instruction register
    input  logic                                stateActive,  // This T-state is current
    output logic [decodeTablePkg::NUM_ROWS-1:0] rowHits       // One bit per PLA row
);
    import decodeTablePkg::*;

    for (genvar r = 0; r < NUM_ROWS; r++) begin : gRow
        if (PLA_ROWS[r].tSel[SLICE_IDX]) begin : gLive
            // Masked byte compare
            assign rowHits[r] = stateActive
                && ((irOpcode.raw & PLA_ROWS[r].mask) == PLA_ROWS[r].value);
        end else begin : gDead
            assign rowHits[r] = 1'b0;                      // Row not live in this state
        end
    end

endmodule

// ==== cycleTimer.sv ====
// T-state sequencer, ready rule with write override, instruction-load strobe and sync
`timescale 1ns/1ps

module cycleTimer (
    input  logic                NMI_L,      // Core clock
    input  logic                rstN,       // Sync reset
    input  logic                rdy,        // External ready
    input  logic                writeNow,   // Write cycle, ignores rdy
    input  logic                lastCycle,  // Instruction ends this cycle
    output cpuTypesPkg::tStateT tState,     // One-hot T0..T5
    output logic                ready,      // Processor runs this cycle
    output logic                irLoad,     // One-cycle load strobe
    output logic                sync        // High in T0
);
    import cpuTypesPkg::*;

    assign ready  = rdy | writeNow;        // Writes never stall
    assign irLoad = lastCycle & ready;
    assign sync   = (tState == TS_T0);

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            tState <= TS_T0;
        end else if (irLoad) begin
            tState <= TS_T0;                                     // New instruction
        end else if (ready) begin
            tState <= {tState[NUM_T_STATES-2:0], tState[NUM_T_STATES-1]};  // Next T-state
        end
    end

    timerOneHotAssert: assert property (@(posedge NMI_L) disable iff (!rstN)
        $onehot(tState));

endmodule

// ==== interruptControl.sv ====
// NMI edge capture, IRQ and reset pending latches, priority pick and active source
`timescale 1ns/1ps

module interruptControl (
    input  logic                   NMI_L,         // Core clock
    input  logic                   rstN,          // Sync reset
    input  cpuTypesPkg::intReqT    intReq,        // Request pins, active low
    input  logic                   irLoad,        // Instruction load strobe
    output logic                   forceInt,      // Some source pending
    output cpuTypesPkg::intSourceT activeSource   // Source now being serviced
);
    import cpuTypesPkg::*;

    logic      nmiSampled;  // nmiN at this edge
    logic      nmiPrev;     // nmiN one edge back
    logic      nmiPend;
    logic      irqPend;
    logic      resPend;
    logic      take;        // Load consumes a source
    intSourceT nextSource;  // Winner by priority

    assign forceInt = nmiPend | irqPend | resPend;
    assign take     = irLoad & forceInt;

    // RES, then NMI, then IRQ
    always_comb begin
        nextSource = SRC_NONE;
        if (resPend) begin
            nextSource = SRC_RES;
        end else if (nmiPend) begin
            nextSource = SRC_NMI;
        end else if (irqPend) begin
            nextSource = SRC_IRQ;
        end
    end

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            nmiSampled   <= 1'b1;
            nmiPrev      <= 1'b1;
            nmiPend      <= 1'b0;
            irqPend      <= 1'b0;
            resPend      <= 1'b0;
            activeSource <= SRC_RES;
        end else begin
            nmiSampled <= intReq.nmiN;
            nmiPrev    <= nmiSampled;
            if (nmiPrev && !nmiSampled) begin                    // Fresh edge beats a clear
                nmiPend <= 1'b1;
            end else if (take && nextSource == SRC_NMI) begin
                nmiPend <= 1'b0;
            end
            if (take && nextSource == SRC_IRQ) begin
                irqPend <= 1'b0;                                 // Relatches if still held
            end else if (!intReq.irqN) begin
                irqPend <= 1'b1;
            end
            if (take && nextSource == SRC_RES) begin
                resPend <= 1'b0;
            end else if (!intReq.resN) begin
                resPend <= 1'b1;
            end
            if (take) begin
                activeSource <= nextSource;
            end
        end
    end

    // Source switches only at an instruction boundary
    srcOnLoadAssert: assert property (@(posedge NMI_L) disable iff (!rstN)
        $changed(activeSource) |-> $past(irLoad && forceInt));

endmodule

// ==== fetchStage.sv ====
// Predecode register, interrupt opcode forcing and instruction register
`timescale 1ns/1ps

module fetchStage (
    input  logic                           NMI_L,     // Core clock
    input  logic                           rstN,      // Sync reset
    input  logic [cpuTypesPkg::DATA_W-1:0] dataIn,    // External data bus
    input  logic                           ready,     // Processor runs this cycle
    input  logic                           irLoad,    // Instruction ends, load IR
    input  logic                           forceInt,  // Interrupt pending
    output cpuTypesPkg::opcodeU            irOpcode   // Instruction register
);
    import cpuTypesPkg::*;
    import decodeTablePkg::*;

    logic [DATA_W-1:0] predecode;  // Bus byte from the last ready cycle

    // Bus sampled on every ready edge
    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            predecode <= '0;
        end else if (ready) begin
            predecode <= dataIn;
        end
    end

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            irOpcode.raw <= '0;                                  // BRK after reset
        end else if (irLoad) begin
            irOpcode.raw <= forceInt ? INT_OPCODE : predecode;   // Interrupt wins over fetch
        end
    end

    // IR moves only on the edge that closes an instruction
    irOnLoadAssert: assert property (@(posedge NMI_L) disable iff (!rstN)
        $changed(irOpcode.raw) |-> $past(irLoad));

endmodule

// ==== decodeTablePkg.sv ====
// Decode PLA row type, row builders, control-bit indices, row table and interrupt opcode
package decodeTablePkg;

    localparam int NUM_ROWS = 28;                              // Rows kept from the full PLA
    localparam logic [cpuTypesPkg::DATA_W-1:0] INT_OPCODE = 8'h00;  // BRK forced on interrupt
    localparam cpuTypesPkg::tStateT TS_ANY = '1;               // Row live in every state

    // Bit positions inside ctrlWordT
    localparam int IDX_END_INSTR  = 0;
    localparam int IDX_INT_SEQ    = 1;
    localparam int IDX_JUMP       = 2;
    localparam int IDX_PULL_STACK = 3;
    localparam int IDX_PUSH_STACK = 4;
    localparam int IDX_STORE_A    = 5;
    localparam int IDX_LOAD_A     = 6;
    localparam int IDX_ALU_SBC    = 7;
    localparam int IDX_ALU_ADC    = 8;
    localparam int IDX_ALU_EOR    = 9;
    localparam int IDX_ALU_AND    = 10;
    localparam int IDX_ALU_OR     = 11;

    typedef struct packed {
        logic [cpuTypesPkg::DATA_W-1:0] mask;     // Opcode bits that matter
        logic [cpuTypesPkg::DATA_W-1:0] value;    // Required value of those bits
        cpuTypesPkg::tStateT            tSel;     // One-hot state or TS_ANY
        logic [cpuTypesPkg::CTRL_W-1:0] ctrlBit;  // One-hot control output
    } plaRowT;

    // Opcode byte from group fields
    function automatic logic [cpuTypesPkg::DATA_W-1:0] grpByte(
        input logic [2:0] aaa,
        input logic [2:0] bbb,
        input logic [1:0] cc
    );
        cpuTypesPkg::opcodeU op;
        op.grp.aaa = aaa;
        op.grp.bbb = bbb;
        op.grp.cc  = cc;
        return op.raw;
    endfunction

    function automatic plaRowT mkRow(
        input logic [cpuTypesPkg::DATA_W-1:0] mask,
        input logic [cpuTypesPkg::DATA_W-1:0] value,
        input cpuTypesPkg::tStateT            tSel,
        input int                             idx
    );
        plaRowT row;
        row.mask         = mask;
        row.value        = value;
        row.tSel         = tSel;
        row.ctrlBit      = '0;
        row.ctrlBit[idx] = 1'b1;
        return row;
    endfunction

    localparam logic [cpuTypesPkg::DATA_W-1:0] GRP1_OP_MASK   = grpByte(3'b111, 3'b000, 2'b11);
    localparam logic [cpuTypesPkg::DATA_W-1:0] GRP1_MODE_MASK = grpByte(3'b000, 3'b111, 2'b11);

    localparam plaRowT PLA_ROWS [NUM_ROWS] = '{
        mkRow(GRP1_OP_MASK, grpByte(3'b000, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_ALU_OR),
        mkRow(GRP1_OP_MASK, grpByte(3'b001, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_ALU_AND),
        mkRow(GRP1_OP_MASK, grpByte(3'b010, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_ALU_EOR),
        mkRow(GRP1_OP_MASK, grpByte(3'b011, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_ALU_ADC),
        mkRow(GRP1_OP_MASK, grpByte(3'b111, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_ALU_SBC),
        mkRow(GRP1_OP_MASK, grpByte(3'b101, 3'b000, 2'b01), cpuTypesPkg::TS_T0, IDX_LOAD_A),
        mkRow(GRP1_MODE_MASK, grpByte(3'b000, 3'b010, 2'b01), cpuTypesPkg::TS_T1,
              IDX_END_INSTR),                                                  // Immediate ends
        mkRow(GRP1_MODE_MASK, grpByte(3'b000, 3'b001, 2'b01), cpuTypesPkg::TS_T2,
              IDX_END_INSTR),                                                  // Zero page ends
        mkRow(GRP1_MODE_MASK, grpByte(3'b000, 3'b011, 2'b01), cpuTypesPkg::TS_T3,
              IDX_END_INSTR),                                                  // Absolute ends
        mkRow(8'hFF, grpByte(3'b100, 3'b001, 2'b01), cpuTypesPkg::TS_T2, IDX_STORE_A),  // STA zp
        mkRow(8'hFF, grpByte(3'b100, 3'b011, 2'b01), cpuTypesPkg::TS_T3, IDX_STORE_A),  // STA abs
        mkRow(GRP1_OP_MASK, grpByte(3'b100, 3'b000, 2'b01), cpuTypesPkg::TS_T5,
              IDX_STORE_A),                                                    // STA long modes
        mkRow(8'hBF, 8'h08, cpuTypesPkg::TS_T2, IDX_PUSH_STACK),  // PHA PHP
        mkRow(8'hBF, 8'h08, cpuTypesPkg::TS_T2, IDX_END_INSTR),
        mkRow(8'hBF, 8'h28, cpuTypesPkg::TS_T3, IDX_PULL_STACK),  // PLA PLP
        mkRow(8'hBF, 8'h28, cpuTypesPkg::TS_T3, IDX_END_INSTR),
        mkRow(8'hFF, 8'h68, cpuTypesPkg::TS_T3, IDX_LOAD_A),      // PLA into A
        mkRow(8'hFF, 8'h4C, cpuTypesPkg::TS_T2, IDX_JUMP),        // JMP abs
        mkRow(8'hFF, 8'h4C, cpuTypesPkg::TS_T2, IDX_END_INSTR),
        mkRow(8'hFF, 8'h6C, cpuTypesPkg::TS_T4, IDX_JUMP),        // JMP ind
        mkRow(8'hFF, 8'h6C, cpuTypesPkg::TS_T4, IDX_END_INSTR),
        mkRow(8'hDF, 8'h00, cpuTypesPkg::TS_T2, IDX_PUSH_STACK),  // JSR and BRK, PC high
        mkRow(8'hDF, 8'h00, cpuTypesPkg::TS_T3, IDX_PUSH_STACK),  // PC low
        mkRow(8'h1F, 8'h00, cpuTypesPkg::TS_T5, IDX_JUMP),        // BRK JSR RTI RTS
        mkRow(8'hDF, 8'h40, cpuTypesPkg::TS_T3, IDX_PULL_STACK),  // RTI RTS
        mkRow(8'hDF, 8'h40, cpuTypesPkg::TS_T4, IDX_PULL_STACK),
        mkRow(8'hFF, INT_OPCODE, TS_ANY, IDX_INT_SEQ),            // Whole BRK sequence
        mkRow(8'hFF, INT_OPCODE, cpuTypesPkg::TS_T4, IDX_PUSH_STACK)  // Status push
    };

endpackage

// ==== cpuTypesPkg.sv ====
// Bus widths, opcode union, T-state, control word and interrupt request types
package cpuTypesPkg;

    localparam int DATA_W       = 8;   // Data bus and opcode width
    localparam int NUM_T_STATES = 6;   // T0 to T5
    localparam int CTRL_W       = 12;  // Control word width

    // Opcode seen as a byte by the PLA, as group fields by the row table
    typedef union packed {
        logic [DATA_W-1:0] raw;        // Whole byte
        struct packed {
            logic [2:0] aaa;           // Operation inside the group
            logic [2:0] bbb;           // Addressing mode
            logic [1:0] cc;            // Instruction group
        } grp;
    } opcodeU;

    typedef logic [NUM_T_STATES-1:0] tStateT;  // One-hot timing state

    localparam tStateT TS_T0 = 6'b000001;      // Fetch, sync high
    localparam tStateT TS_T1 = 6'b000010;
    localparam tStateT TS_T2 = 6'b000100;
    localparam tStateT TS_T3 = 6'b001000;
    localparam tStateT TS_T4 = 6'b010000;
    localparam tStateT TS_T5 = 6'b100000;      // Always the last cycle

    // First field is the MSB, endInstr sits in bit 0
    typedef struct packed {
        logic aluOr;      // ALU ops
        logic aluAnd;
        logic aluEor;
        logic aluAdc;
        logic aluSbc;
        logic loadA;      // Accumulator load
        logic storeA;     // Bus write of A
        logic pushStack;  // Bus write to stack
        logic pullStack;  // Stack read
        logic jump;       // PC reload
        logic intSeq;     // Interrupt sequence running
        logic endInstr;   // Instruction ends this cycle
    } ctrlWordT;

    typedef enum logic [1:0] {
        SRC_NONE,         // No source serviced
        SRC_NMI,
        SRC_IRQ,
        SRC_RES
    } intSourceT;

    // Request pins, all active low
    typedef struct packed {
        logic nmiN;       // Edge sensitive
        logic irqN;       // Level sensitive
        logic resN;       // Level sensitive
    } intReqT;

endpackage
